// ==== sim/cache_cases.txt ====
# op(R/W) addr wdata hit rdata; addr, wdata and rdata in hex, hit is 0 or 1
# rdata is checked on reads only; memory starts as byte address xor a5a5
R 0014 0000 0 a5b1
R 0010 0000 1 a5b5
R 0016 0000 1 a5b3
R 0022 0000 0 a587
R 002e 0000 0 a58b
R 0028 0000 1 a58d
W 0012 1234 1 0000
R 0012 0000 1 1234
W 0102 beef 0 0000
R 0106 0000 1 a4a3
R 0102 0000 1 beef
R 0904 0000 0 aca1
R 0102 0000 0 beef
R 0106 0000 1 a4a3
W 0812 5678 0 0000
R 0810 0000 1 adb5
R 0812 0000 1 5678
R 0012 0000 0 1234
R 0010 0000 1 a5b5
R 0812 0000 0 5678

// ==== cache_top.f ====
logic/cache_pkg.sv
logic/cache_ifs.sv
logic/tag_store.sv
logic/data_store.sv
logic/mem_port.sv
logic/cache_ctrl.sv
logic/cache_top.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cache_tb -f cache_top.f
out=$(./obj_dir/Vcache_tb) || true
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== sim/cache_tb.sv ====
// cache testbench; accesses and expected results come from sim/cache_cases.txt
// memory model answers each bus cycle after 0 to 3 random wait states

module cache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_CASE = 200;
	localparam int MEM_WORDS = 32768;

	logic clk;
	logic reset;
	logic req_rd;
	logic req_wr;
	cache_pkg::addr_t req_addr;
	cache_pkg::word_t req_wdata;
	cache_pkg::word_t rdata;
	logic done;
	logic busy;
	logic hit;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	cache_pkg::addr_t wb_adr;
	cache_pkg::word_t wb_dat_o;
	cache_pkg::word_t wb_dat_i;
	logic wb_ack;

	// one entry per case line
	logic case_wr [$];
	cache_pkg::addr_t case_addr [$];
	cache_pkg::word_t case_wdata [$];
	logic case_hit [$];
	cache_pkg::word_t case_rdata [$];
	logic cases_loaded;
	int errors;

	cache_pkg::word_t mem_words [MEM_WORDS];
	logic [15:0] lfsr;
	logic [1:0] waits;
	logic [1:0] wait_left;
	logic xfer_open;

	cache_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic check_val(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic run_case(input int n);
		int lat;
		@(posedge clk);
		req_rd <= ~case_wr[n];
		req_wr <= case_wr[n];
		req_addr <= case_addr[n];
		req_wdata <= case_wdata[n];
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!done);
		check_val($sformatf("hit (case %0d)", n), 16'(hit), 16'(case_hit[n]));
		if (!case_wr[n]) begin
			check_val($sformatf("rdata (case %0d)", n), rdata, case_rdata[n]);
		end
		// a hit ends in its request cycle
		if (case_hit[n]) begin
			check_val($sformatf("done latency (case %0d)", n), 16'(lat), 16'd1);
		end
		@(posedge clk);
		req_rd <= 1'b0;
		req_wr <= 1'b0;
		// fill may run on after an early done
		do begin
			@(negedge clk);
		end while (busy);
	endtask

	// Wishbone slave, writes kept so evicted lines read back later
	initial begin
		lfsr = 16'd97;
		wb_ack <= 1'b0;
		wb_dat_i <= '0;
		xfer_open <= 1'b0;
		wait_left <= 2'd0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_words[i[14:0]] = {i[14:0], 1'b0} ^ 16'hA5A5;
		end
		forever begin
			@(posedge clk);
			if (reset || wb_ack) begin
				wb_ack <= 1'b0;
				xfer_open <= 1'b0;
			end else if (wb_cyc && wb_stb) begin
				if (xfer_open) begin
					waits = wait_left;
				end else begin
					waits[0] = lfsr[0];
					lfsr = lfsr_step(lfsr);
					waits[1] = lfsr[0];
					lfsr = lfsr_step(lfsr);
				end
				xfer_open <= 1'b1;
				if (waits == 2'd0) begin
					wb_ack <= 1'b1;
					if (wb_we) begin
						mem_words[wb_adr[15:1]] = wb_dat_o;
					end else begin
						wb_dat_i <= mem_words[wb_adr[15:1]];
					end
				end else begin
					wait_left <= waits - 2'd1;
				end
			end
		end
	end

	initial begin
		int fd;
		int nread;
		int fields;
		string line;
		logic [7:0] op_c;
		cache_pkg::addr_t a;
		cache_pkg::word_t wd;
		int eh;
		cache_pkg::word_t ed;

		reset <= 1'b1;
		req_rd <= 1'b0;
		req_wr <= 1'b0;
		req_addr <= '0;
		req_wdata <= '0;
		errors = 0;
		cases_loaded = 1'b0;

		fd = $fopen("sim/cache_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file sim/cache_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				nread = $fgets(line, fd);
				// skip blank and comment lines
				if (nread > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%c %h %h %d %h", op_c, a, wd, eh, ed);
					if (fields == 5) begin
						case_wr.push_back(op_c == "W");
						case_addr.push_back(a);
						case_wdata.push_back(wd);
						case_hit.push_back(eh != 0);
						case_rdata.push_back(ed);
					end else begin
						$display("case line could not be read: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (case_wr.size() == 0) begin
			$display("no cases were read from the case file");
			errors++;
		end
		cases_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("done after reset", 16'(done), 16'd0);
		check_val("busy after reset", 16'(busy), 16'd0);
		check_val("hit after reset", 16'(hit), 16'd0);
		check_val("wb_cyc after reset", 16'(wb_cyc), 16'd0);
		check_val("wb_stb after reset", 16'(wb_stb), 16'd0);

		for (int n = 0; n < case_wr.size(); n++) begin
			run_case(n);
		end

		$display("%0d cases, %0d check errors, %0d assertion failures",
			case_wr.size(), errors, dut_i.asserts_i.fail_count);
		if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog, limit scales with the number of cases
	initial begin
		wait (cases_loaded);
		repeat (case_wr.size() * CYCLES_PER_CASE + RESET_CYCLES) @(posedge clk);
		$display("timeout: the cache did not finish all cases in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim/cache_asserts.sv ====
// protocol checks bound into cache_top, inactive while reset is high
// bus checks assume single-word classic cycles

module cache_asserts (
	input logic              clk,
	input logic              reset,
	input logic              req_rd,
	input logic              req_wr,
	input logic              done,
	input logic              busy,
	input logic              hit,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic              wb_we,
	input cache_pkg::addr_t  wb_adr,
	input cache_pkg::word_t  wb_dat_o,
	input logic              wb_ack
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;

	stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
		wb_stb |-> wb_cyc)
		else begin
			$error("wb_stb high outside a bus cycle");
			fail_count++;
		end

	// address, direction and data held until ack
	held_until_ack: assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_we)
			&& $stable(wb_dat_o)))
		else begin
			$error("bus cycle changed or ended before ack");
			fail_count++;
		end

	idle_after_ack: assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && wb_ack) |=> !wb_cyc)
		else begin
			$error("wb_cyc stayed high after ack");
			fail_count++;
		end

	done_needs_req: assert property (@(posedge clk) disable iff (reset)
		done |-> (req_rd || req_wr))
		else begin
			$error("done without a pending request");
			fail_count++;
		end

	// a hit finishes at once and never starts miss handling
	no_hit_busy: assert property (@(posedge clk) disable iff (reset)
		(done && hit) |=> !busy)
		else begin
			$error("cache went busy right after a hit");
			fail_count++;
		end

endmodule

bind cache_top cache_asserts asserts_i (
	.clk(clk), .reset(reset),
	.req_rd(req_rd), .req_wr(req_wr),
	.done(done), .busy(busy), .hit(hit),
	.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
	.wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
);

// ==== logic/cache_top.sv ====
// direct-mapped write-back data cache between a 16-bit load/store port and
// a Wishbone classic memory. INDEX_W + TAG_W must equal 13 for 16-bit addresses.
// processor side uses the req/done handshake, busy blocks new requests

module cache_top #(
	parameter int INDEX_W = $bits(cache_pkg::index_t),
	parameter int TAG_W = $bits(cache_pkg::tag_t)
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              req_rd,
	input  logic              req_wr,
	input  cache_pkg::addr_t  req_addr,
	input  cache_pkg::word_t  req_wdata,
	output cache_pkg::word_t  rdata,
	output logic              done,
	output logic              busy,
	output logic              hit,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output cache_pkg::addr_t  wb_adr,
	output cache_pkg::word_t  wb_dat_o,
	input  cache_pkg::word_t  wb_dat_i,
	input  logic              wb_ack
);

	tag_if #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) tag_bus ();
	data_if #(.INDEX_W(INDEX_W)) data_bus ();
	mem_if mem_bus ();

	cache_ctrl #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) ctrl_i (
		.clk(clk), .reset(reset),
		.req_rd(req_rd), .req_wr(req_wr),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.tag(tag_bus.ctrl), .data(data_bus.ctrl), .mem(mem_bus.ctrl),
		.done(done), .busy(busy), .hit(hit), .rdata(rdata)
	);

	tag_store #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) tag_i (
		.clk(clk), .reset(reset), .tag(tag_bus.store)
	);

	data_store #(.INDEX_W(INDEX_W)) data_i (
		.clk(clk), .data(data_bus.store)
	);

	mem_port mem_i (
		.clk(clk), .reset(reset), .mem(mem_bus.port),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

endmodule

// ==== logic/cache_ctrl.sv ====
// miss handling controller: write-back of a dirty victim, then a wrapped fill
// starting at the requested word. One miss at a time; hits finish combinationally.
// the requester must hold its request until done and present nothing while busy

module cache_ctrl #(
	parameter int INDEX_W = 8,
	parameter int TAG_W = 5
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              req_rd,
	input  logic              req_wr,
	input  cache_pkg::addr_t  req_addr,
	input  cache_pkg::word_t  req_wdata,
	tag_if.ctrl               tag,
	data_if.ctrl              data,
	mem_if.ctrl               mem,
	output logic              done,
	output logic              busy,
	output logic              hit,
	output cache_pkg::word_t  rdata
);

	localparam cache_pkg::word_sel_t LAST =
		cache_pkg::word_sel_t'(cache_pkg::WORDS_PER_LINE - 1);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t nxt_state;

	logic [TAG_W-1:0] req_tag;
	logic [INDEX_W-1:0] req_index;
	cache_pkg::word_sel_t req_word;

	// the missing request, held through write-back and fill
	logic [TAG_W-1:0] lat_tag;
	logic [INDEX_W-1:0] lat_index;
	cache_pkg::word_sel_t lat_word;
	cache_pkg::word_t lat_wdata;
	logic lat_wr;

	cache_pkg::word_sel_t cnt;
	cache_pkg::word_sel_t fill_sel;
	cache_pkg::addr_t wb_addr;
	cache_pkg::addr_t fill_addr;

	logic idle;
	logic req;
	logic miss;

	assign req_tag = req_addr[cache_pkg::ADDR_W-1 -: TAG_W];
	assign req_index = req_addr[cache_pkg::OFFSET_W +: INDEX_W];
	assign req_word = req_addr[1 +: cache_pkg::WSEL_W];

	assign idle = (state == cache_pkg::IDLE);
	assign req = req_rd | req_wr;
	assign miss = idle & req & ~tag.hit;

	// wrapped fill order, critical word first
	assign fill_sel = lat_word + cnt;
	assign wb_addr = {tag.victim_tag, lat_index, cnt, 1'b0};
	assign fill_addr = {lat_tag, lat_index, fill_sel, 1'b0};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_pkg::IDLE;
		end else begin
			state <= nxt_state;
		end
	end

	always_comb begin
		nxt_state = state;
		case (state)
			cache_pkg::IDLE: begin
				if (miss) begin
					nxt_state = tag.dirty ? cache_pkg::WB : cache_pkg::FILL;
				end
			end
			cache_pkg::WB: begin
				if (mem.fin && cnt == LAST) begin
					nxt_state = cache_pkg::FILL;
				end
			end
			cache_pkg::FILL: begin
				if (mem.fin && cnt == LAST) begin
					nxt_state = lat_wr ? cache_pkg::WR_DONE : cache_pkg::FILL_END;
				end
			end
			cache_pkg::FILL_END: nxt_state = cache_pkg::IDLE;
			cache_pkg::WR_DONE: nxt_state = cache_pkg::IDLE;
			default: nxt_state = cache_pkg::IDLE;
		endcase
	end

	// word counter, wraps to zero between write-back and fill
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (idle) begin
			cnt <= '0;
		end else if (mem.fin) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (miss) begin
			lat_tag <= req_tag;
			lat_index <= req_index;
			lat_word <= req_word;
			lat_wdata <= req_wdata;
			lat_wr <= req_wr;
		end
	end

	// tag side: compare on the live request, later on the latched one
	assign tag.index = idle ? req_index : lat_index;
	assign tag.tag = idle ? req_tag : lat_tag;
	assign tag.tag_we = (idle & req_wr & tag.hit)
		| (state == cache_pkg::FILL & mem.fin & cnt == '0)
		| (state == cache_pkg::FILL_END)
		| (state == cache_pkg::WR_DONE);
	// line is invalid while partly filled
	assign tag.set_valid = (state != cache_pkg::FILL);
	assign tag.set_dirty = idle | (state == cache_pkg::WR_DONE);

	// data side
	always_comb begin
		case (state)
			cache_pkg::IDLE: data.word_sel = req_word;
			cache_pkg::WB: data.word_sel = cnt;
			cache_pkg::FILL: data.word_sel = fill_sel;
			default: data.word_sel = lat_word;
		endcase
	end

	assign data.index = idle ? req_index : lat_index;
	assign data.fill_we = (state == cache_pkg::FILL) & mem.fin;
	assign data.cpu_we = (idle & req_wr & tag.hit) | (state == cache_pkg::WR_DONE);
	assign data.fill_word = mem.rdata;
	assign data.cpu_word = idle ? req_wdata : lat_wdata;

	// bus requests; mem_port takes go only when its cycle is closed
	assign mem.go = (state == cache_pkg::WB) | (state == cache_pkg::FILL);
	assign mem.we = (state == cache_pkg::WB);
	assign mem.adr = (state == cache_pkg::WB) ? wb_addr : fill_addr;
	assign mem.wdata = data.rd_word;

	// read miss ends early on the critical word
	assign done = (idle & req & tag.hit)
		| (state == cache_pkg::FILL & mem.fin & cnt == '0 & ~lat_wr)
		| (state == cache_pkg::WR_DONE);
	assign hit = idle & req & tag.hit;
	assign busy = ~idle;
	assign rdata = idle ? data.rd_word : mem.rdata;

endmodule

// ==== logic/mem_port.sv ====
// Wishbone classic master, one single-word cycle per accepted go
// no error or retry inputs; the slave may stretch ack without limit

module mem_port (
	input  logic              clk,
	input  logic              reset,
	mem_if.port               mem,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output cache_pkg::addr_t  wb_adr,
	output cache_pkg::word_t  wb_dat_o,
	input  cache_pkg::word_t  wb_dat_i,
	input  logic              wb_ack
);

	logic cyc_q;
	logic we_q;
	cache_pkg::addr_t adr_q;
	cache_pkg::word_t dat_q;

	logic start;

	// go is ignored while a cycle is open
	assign start = ~cyc_q & mem.go;

	always_ff @(posedge clk) begin
		if (reset) begin
			cyc_q <= 1'b0;
		end else if (start) begin
			cyc_q <= 1'b1;
		end else if (wb_ack) begin
			// closes for at least one cycle after ack
			cyc_q <= 1'b0;
		end
	end

	// held stable until ack
	always_ff @(posedge clk) begin
		if (start) begin
			we_q <= mem.we;
			adr_q <= mem.adr;
			dat_q <= mem.wdata;
		end
	end

	assign wb_cyc = cyc_q;
	assign wb_stb = cyc_q;
	assign wb_we = we_q;
	assign wb_adr = adr_q;
	assign wb_dat_o = dat_q;

	assign mem.fin = cyc_q & wb_ack;
	assign mem.rdata = wb_dat_i;

endmodule

// ==== logic/data_store.sv ====
// line data array, one word read and one word written per cycle
// fill and processor writes never happen in the same cycle

module data_store #(
	parameter int INDEX_W = 8
) (
	input  logic  clk,
	data_if.store data
);

	localparam int LINES = 2 ** INDEX_W;

	cache_pkg::word_t lines [LINES][cache_pkg::WORDS_PER_LINE];

	cache_pkg::word_t wr_word;
	logic wr_en;

	// fill data takes priority in the mux
	assign wr_word = data.fill_we ? data.fill_word : data.cpu_word;
	assign wr_en = data.fill_we | data.cpu_we;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			lines[data.index][data.word_sel] <= wr_word;
		end
	end

	// asynchronous word read
	assign data.rd_word = lines[data.index][data.word_sel];

endmodule

// ==== logic/tag_store.sv ====
// tag, valid and dirty bits per line with asynchronous read and hit compare
// reset clears only the valid bits; dirty reads as zero on an invalid line

module tag_store #(
	parameter int INDEX_W = 8,
	parameter int TAG_W = 5
) (
	input  logic clk,
	input  logic reset,
	tag_if.store tag
);

	localparam int LINES = 2 ** INDEX_W;

	logic [TAG_W-1:0] tags [LINES];
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;

	logic line_valid;

	// whole valid vector cleared in one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (tag.tag_we) begin
			valid_q[tag.index] <= tag.set_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (tag.tag_we) begin
			tags[tag.index] <= tag.tag;
			dirty_q[tag.index] <= tag.set_dirty;
		end
	end

	assign line_valid = valid_q[tag.index];

	assign tag.hit = line_valid & (tags[tag.index] == tag.tag);
	assign tag.dirty = line_valid & dirty_q[tag.index];
	assign tag.victim_tag = tags[tag.index];

endmodule

// ==== logic/cache_ifs.sv ====
// internal buses between the cache controller and its datapath blocks
// widths of index and tag follow the parameters set in cache_top

interface tag_if #(
	parameter int INDEX_W = 8,
	parameter int TAG_W = 5
);
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0] tag;
	logic tag_we;
	logic set_valid;
	logic set_dirty;
	logic hit;
	logic dirty;
	logic [TAG_W-1:0] victim_tag;

	modport ctrl (output index, tag, tag_we, set_valid, set_dirty,
		input hit, dirty, victim_tag);
	modport store (input index, tag, tag_we, set_valid, set_dirty,
		output hit, dirty, victim_tag);
endinterface

interface data_if #(
	parameter int INDEX_W = 8
);
	logic [INDEX_W-1:0] index;
	cache_pkg::word_sel_t word_sel;
	logic fill_we;
	logic cpu_we;
	cache_pkg::word_t fill_word;
	cache_pkg::word_t cpu_word;
	cache_pkg::word_t rd_word;

	modport ctrl (output index, word_sel, fill_we, cpu_we, fill_word, cpu_word,
		input rd_word);
	modport store (input index, word_sel, fill_we, cpu_we, fill_word, cpu_word,
		output rd_word);
endinterface

interface mem_if;
	logic go;
	logic we;
	cache_pkg::addr_t adr;
	cache_pkg::word_t wdata;
	logic fin;
	cache_pkg::word_t rdata;

	modport ctrl (output go, we, adr, wdata, input fin, rdata);
	modport port (input go, we, adr, wdata, output fin, rdata);
endinterface

// ==== logic/cache_pkg.sv ====
// shared widths and types for the direct-mapped data cache
// addresses are 16-bit byte addresses; tag + index + 3 offset bits must total 16
// line size is fixed here; the fill counter width follows it

package cache_pkg;

	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;

	// four 16-bit words per line
	localparam int WORDS_PER_LINE = 4;
	localparam int WSEL_W = $clog2(WORDS_PER_LINE);

	// word select plus the byte bit
	localparam int OFFSET_W = WSEL_W + 1;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;

	// default split, cache_top derives its parameters from these
	typedef logic [4:0] tag_t;
	typedef logic [7:0] index_t;

	typedef logic [WSEL_W-1:0] word_sel_t;

	// miss handling states
	typedef enum logic [2:0] {
		IDLE,
		WB,
		FILL,
		FILL_END,
		WR_DONE
	} ctrl_state_t;

endpackage
